/* acquire_top.f */
logic/acquire_pkg.sv
logic/capture_buffer.sv
logic/transfer_scheduler.sv
logic/sample_store.sv
logic/acquire_top.sv
tb/acquire_sva.sv
tb/acquire_tb.sv

/* Makefile */
# Verilator build and run for the acquisition path

VERILATOR ?= verilator
TOP       ?= acquire_tb
FILELIST  ?= acquire_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

FAIL_MSG := *** FAILED ***
PASS_MSG := *** PASSED ***

SOURCES := $(wildcard logic/*.sv tb/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/acquire_tb.sv */
`timescale 1ns/1ps

module acquire_tb
   import acquire_pkg::*;
();

   localparam int CLOCK_PERIOD    = 4;
   localparam int NUM_SAMPLES     = STORE_DEPTH;   // exactly fills the store
   localparam int MIN_SPACING     = 4;
   localparam int MAX_SPACING     = 8;
   localparam int MAX_ACK_DELAY   = 10;
   localparam int EXTRA_SAMPLES   = 4;
   localparam int WAIT_LIMIT      = 200;   // cycles allowed for one handshake
   localparam int WATCHDOG_CYCLES = NUM_SAMPLES * (MAX_SPACING + STORE_BUSY + 20) * 2;

   logic                clock;
   logic                reset;
   logic                sample_strobe;
   logic [SAMPLE_W-1:0] sample_data;
   logic                read_ack;
   readback_t           readback;
   acq_phase_t          phase;

   integer              seed = 32'hfc1f1079;
   logic [SAMPLE_W-1:0] model_q [$];   // words in order of arrival
   int                  error_count  = 0;
   int                  tests_run    = 0;
   int                  tests_failed = 0;
   int                  early_reads  = 0;
   int                  valid_count  = 0;

   acquire_top uut
   (
      .clock         (clock),
      .reset         (reset),
      .sample_strobe (sample_strobe),
      .sample_data   (sample_data),
      .read_ack      (read_ack),
      .readback      (readback),
      .phase         (phase)
   );

   always #(CLOCK_PERIOD / 2) clock = ~clock;

   // every readback pulse, counted where outputs are settled
   always @(negedge clock)
   begin
      if (readback.valid)
         valid_count <= valid_count + 1;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLOCK_PERIOD);
      $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("*** FAILED ***");
      $finish;
   end

   task automatic check_word(input string test, input logic [CMD_DATA_W-1:0] expected,
                             input logic [CMD_DATA_W-1:0] actual);
      if (actual !== expected)
      begin
         $display("** Error %s: expected %h, actual %h", test, expected, actual);
         error_count++;
      end
   endtask

   task automatic check_phase(input string test, input acq_phase_t expected,
                              input acq_phase_t actual);
      if (actual !== expected)
      begin
         $display("** Error %s: expected %s, actual %s (%0d)", test, expected.name(),
                  actual.name(), actual);
         error_count++;
      end
   endtask

   task automatic note_failure(input string test, input string what);
      $display("%s: %s", test, what);
      error_count++;
   endtask

   task automatic finish_test(input string name, input int failures);
      tests_run++;
      if (failures == 0)
         $display("test %s: ok", name);
      else
      begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, failures);
      end
   endtask

   // called on a falling edge, returns on the falling edge of the next slot
   task automatic send_sample(input logic [SAMPLE_W-1:0] word, input int spacing,
                              input bit watch_fill);
      sample_strobe = 1'b1;
      sample_data   = word;   // held until the next strobe
      for (int i = 0; i < spacing; i++)
      begin
         @(negedge clock);
         sample_strobe = 1'b0;
         if (watch_fill && (phase inside {phase_store_reading, phase_read_idle,
                                          phase_finished}))
            early_reads++;
      end
   endtask

   task automatic wait_for_phase(input acq_phase_t target, output bit reached);
      reached = 1'b0;
      for (int i = 0; i < WAIT_LIMIT && !reached; i++)
      begin
         @(negedge clock);
         reached = (phase == target);
      end
   endtask

   task automatic wait_for_valid(output bit arrived);
      arrived = 1'b0;
      for (int i = 0; i < WAIT_LIMIT && !arrived; i++)
      begin
         @(negedge clock);
         arrived = readback.valid;
      end
   endtask

   task automatic pulse_ack();
      read_ack = 1'b1;
      @(negedge clock);
      read_ack = 1'b0;
   endtask

   initial
   begin
      bit                    reached;
      bit                    arrived;
      int                    r;
      int                    spacing;
      int                    delay;
      int                    mark;
      int                    pacing_errors;
      logic [SAMPLE_W-1:0]   word;
      logic [CMD_DATA_W-1:0] expected;

      clock         = 1'b0;
      reset         = 1'b1;
      sample_strobe = 1'b0;
      sample_data   = '0;
      read_ack      = 1'b0;
      repeat (3) @(negedge clock);
      reset = 1'b0;

      // reset state
      mark = error_count;
      @(negedge clock);
      check_phase("reset_state", phase_waiting, phase);
      if (readback.valid)
         note_failure("reset_state", "readback.valid is high after reset");
      finish_test("reset_state", error_count - mark);

      // fill the store with random words at random spacing
      mark = error_count;
      for (int i = 0; i < NUM_SAMPLES; i++)
      begin
         r       = $random(seed);
         word    = r[SAMPLE_W-1:0];
         r       = $random(seed);
         spacing = MIN_SPACING + int'($unsigned(r) % (MAX_SPACING - MIN_SPACING + 1));
         model_q.push_back(word);
         if (i < NUM_SAMPLES - 1)
            send_sample(word, spacing, 1'b1);
         else
            send_sample(word, 1, 1'b0);   // read-back may start right after the last one
      end
      if (early_reads > 0)
         note_failure("fill", $sformatf("read-back phase seen %0d times before the last sample",
                                        early_reads));
      wait_for_phase(phase_read_idle, reached);
      if (!reached)
         note_failure("fill", $sformatf("phase_read_idle not reached within %0d cycles",
                                        WAIT_LIMIT));
      finish_test("fill", error_count - mark);

      // read back every word, acking each one after a random pause
      mark          = error_count;
      pacing_errors = 0;
      for (int i = 0; i < NUM_SAMPLES; i++)
      begin
         wait_for_valid(arrived);
         if (!arrived)
         begin
            note_failure("readback", $sformatf("word %0d did not arrive within %0d cycles",
                                               i, WAIT_LIMIT));
            break;
         end
         expected = CMD_DATA_W'(model_q.pop_front());   // zero-extended sample
         check_word($sformatf("readback word %0d", i), expected, readback.data);
         if (i < NUM_SAMPLES - 1)
         begin
            r     = $random(seed);
            delay = int'($unsigned(r) % (MAX_ACK_DELAY + 1));
            for (int d = 0; d < delay; d++)
            begin
               @(negedge clock);
               if (readback.valid)
               begin
                  note_failure("ack_pacing",
                               $sformatf("readback.valid without an ack after word %0d", i));
                  pacing_errors++;
               end
            end
            pulse_ack();
         end
      end
      @(negedge clock);
      finish_test("readback", error_count - mark - pacing_errors);

      mark = error_count;
      if (valid_count != NUM_SAMPLES)
         note_failure("ack_pacing", $sformatf("%0d readback pulses for %0d reads",
                                              valid_count, NUM_SAMPLES));
      finish_test("ack_pacing", error_count - mark + pacing_errors);

      // finished state ignores acks and new samples
      mark = error_count;
      check_phase("finished", phase_finished, phase);
      for (int k = 0; k < 3; k++)
      begin
         repeat (3) @(negedge clock);
         pulse_ack();
      end
      for (int k = 0; k < EXTRA_SAMPLES; k++)
      begin
         r = $random(seed);
         send_sample(r[SAMPLE_W-1:0], MAX_SPACING, 1'b0);
      end
      repeat (40) @(negedge clock);
      if (valid_count != NUM_SAMPLES)
         note_failure("finished", $sformatf("%0d extra readback pulses after the last word",
                                            valid_count - NUM_SAMPLES));
      check_phase("finished", phase_finished, phase);
      finish_test("finished", error_count - mark);

      if (uut.u_transfer_scheduler.sva_check.failures > 0)
      begin
         $display("scheduler assertions failed %0d times",
                  uut.u_transfer_scheduler.sva_check.failures);
         error_count += uut.u_transfer_scheduler.sva_check.failures;
      end

      $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
               error_count);
      if (error_count == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

/* tb/acquire_sva.sv */
`timescale 1ns/1ps

module acquire_sva
   import acquire_pkg::*;
(
   input logic       clock,
   input logic       reset,
   input logic       cmd_enable,
   input logic       cmd_ready,
   input acq_phase_t phase
);

   int failures = 0;   // summed into the testbench error count

   // command strobe is a single-cycle pulse
   enable_one_cycle: assert property (@(posedge clock) disable iff (reset)
      cmd_enable |=> !cmd_enable)
   else
   begin
      failures = failures + 1;
      $error("cmd_enable high for more than one cycle");
   end

   enable_when_ready: assert property (@(posedge clock) disable iff (reset)
      cmd_enable |-> cmd_ready)
   else
   begin
      failures = failures + 1;
      $error("cmd_enable while the store is busy");
   end

   // no restart once all words are read back
   finished_holds: assert property (@(posedge clock) disable iff (reset)
      (phase == phase_finished) |=> (phase == phase_finished))
   else
   begin
      failures = failures + 1;
      $error("phase left phase_finished");
   end

endmodule

bind transfer_scheduler acquire_sva sva_check
(
   .clock      (clock),
   .reset      (reset),
   .cmd_enable (cmd_enable),
   .cmd_ready  (cmd_ready),
   .phase      (phase)
);

/* logic/acquire_top.sv */
`timescale 1ns/1ps

module acquire_top
   import acquire_pkg::*;
(
   input  logic                clock,
   input  logic                reset,
   input  logic                sample_strobe,
   input  logic [SAMPLE_W-1:0] sample_data,
   input  logic                read_ack,
   output readback_t           readback,
   output acq_phase_t          phase
);

   // capture buffer <-> scheduler
   logic [BUF_AW-1:0]   write_address;
   logic [BUF_AW-1:0]   read_address;
   logic [SAMPLE_W-1:0] read_data;

   // scheduler <-> store command port
   store_cmd_t cmd;
   logic       cmd_enable;
   logic       cmd_ready;

   capture_buffer u_capture_buffer
   (
      .clock         (clock),
      .reset         (reset),
      .sample_strobe (sample_strobe),
      .sample_data   (sample_data),
      .read_address  (read_address),
      .write_address (write_address),
      .read_data     (read_data)
   );

   transfer_scheduler u_transfer_scheduler
   (
      .clock         (clock),
      .reset         (reset),
      .write_address (write_address),
      .read_address  (read_address),
      .read_data     (read_data),
      .cmd_ready     (cmd_ready),
      .cmd_enable    (cmd_enable),
      .cmd           (cmd),
      .read_ack      (read_ack),
      .phase         (phase)
   );

   // on-chip stand-in for the SDRAM
   sample_store u_sample_store
   (
      .clock      (clock),
      .reset      (reset),
      .cmd_enable (cmd_enable),
      .cmd        (cmd),
      .cmd_ready  (cmd_ready),
      .readback   (readback)
   );

endmodule

/* logic/sample_store.sv */
`timescale 1ns/1ps

module sample_store
   import acquire_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  logic       cmd_enable,
   input  store_cmd_t cmd,
   output logic       cmd_ready,
   output readback_t  readback
);

   logic [CMD_DATA_W-1:0] store_mem [STORE_DEPTH];
   logic [BUSY_W-1:0]     busy_count;
   logic                  cmd_accept;
   logic                  read_accept;

   // read pipeline, the last stage reads the memory
   logic [READ_LATENCY-2:0] pipe_valid;
   logic [STORE_AW-1:0]     pipe_address [READ_LATENCY-1];
   logic                    rb_valid;
   logic [CMD_DATA_W-1:0]   rb_data;

   assign cmd_ready   = (busy_count == '0);
   assign cmd_accept  = cmd_enable && cmd_ready;
   assign read_accept = cmd_accept && !cmd.write;
   assign readback    = '{valid: rb_valid, data: rb_data};

   // busy countdown and valid pipeline
   always_ff @(posedge clock or posedge reset)
   begin
      if (reset)
      begin
         busy_count <= '0;
         pipe_valid <= '0;
         rb_valid   <= 1'b0;
      end
      else
      begin
         if (cmd_accept)
            busy_count <= BUSY_W'(STORE_BUSY);
         else if (busy_count != '0)
            busy_count <= busy_count - 1'b1;

         pipe_valid[0] <= read_accept;
         for (int i = 1; i < READ_LATENCY - 1; i++)
            pipe_valid[i] <= pipe_valid[i-1];
         rb_valid <= pipe_valid[READ_LATENCY-2];
      end
   end

   // memory array and read data path
   always_ff @(posedge clock)
   begin
      if (cmd_accept && cmd.write)
         store_mem[cmd.address] <= cmd.data;

      pipe_address[0] <= cmd.address;
      for (int i = 1; i < READ_LATENCY - 1; i++)
         pipe_address[i] <= pipe_address[i-1];
      rb_data <= store_mem[pipe_address[READ_LATENCY-2]];
   end

endmodule

/* logic/transfer_scheduler.sv */
`timescale 1ns/1ps

module transfer_scheduler
   import acquire_pkg::*;
(
   input  logic                clock,
   input  logic                reset,

   input  logic [BUF_AW-1:0]   write_address,
   output logic [BUF_AW-1:0]   read_address,
   input  logic [SAMPLE_W-1:0] read_data,

   input  logic                cmd_ready,
   output logic                cmd_enable,
   output store_cmd_t          cmd,

   input  logic                read_ack,
   output acq_phase_t          phase
);

   // one bit wider than the store address, top bit marks full / done
   logic [STORE_AW:0] store_wr_ptr;
   logic [STORE_AW:0] store_rd_ptr;

   logic store_full;
   logic reads_done;
   logic buffer_pending;
   logic issue_write;
   logic issue_read;

   assign store_full     = store_wr_ptr[STORE_AW];
   assign reads_done     = store_rd_ptr[STORE_AW];
   assign buffer_pending = (read_address != write_address);

   // a command goes out as soon as the store is ready in the issuing phase
   assign issue_write = (phase == phase_buffer_to_store) && cmd_ready;
   assign issue_read  = (phase == phase_store_reading) && cmd_ready;

   always_ff @(posedge clock or posedge reset)
   begin
      if (reset)
      begin
         phase        <= phase_waiting;
         store_wr_ptr <= '0;
         store_rd_ptr <= '0;
         read_address <= '0;
         cmd_enable   <= 1'b0;
      end
      else
      begin
         cmd_enable <= 1'b0;   // one-cycle strobe

         case (phase)
            phase_waiting:
            begin
               if (store_full)
                  phase <= phase_store_reading;
               else if (buffer_pending)
                  phase <= phase_buffer_to_store;   // read_data settles meanwhile
            end

            phase_buffer_to_store:
            begin
               if (issue_write)
               begin
                  cmd_enable   <= 1'b1;
                  store_wr_ptr <= store_wr_ptr + 1'b1;
                  read_address <= read_address + 1'b1;
                  phase        <= phase_waiting;
               end
            end

            phase_store_reading:
            begin
               if (issue_read)
               begin
                  cmd_enable   <= 1'b1;
                  store_rd_ptr <= store_rd_ptr + 1'b1;
                  phase        <= phase_read_idle;
               end
            end

            phase_read_idle:
            begin
               // host paces the read-back, one ack per word
               if (reads_done)
                  phase <= phase_finished;
               else if (read_ack)
                  phase <= phase_store_reading;
            end

            phase_finished:
               phase <= phase_finished;   // held until reset

            default:
               phase <= phase_waiting;
         endcase
      end
   end

   // command payload, loaded with the strobe
   always_ff @(posedge clock)
   begin
      if (issue_write)
      begin
         cmd.write   <= 1'b1;
         cmd.address <= store_wr_ptr[STORE_AW-1:0];
         cmd.data    <= {{(CMD_DATA_W - SAMPLE_W){1'b0}}, read_data};
      end
      else if (issue_read)
      begin
         cmd.write   <= 1'b0;
         cmd.address <= store_rd_ptr[STORE_AW-1:0];
         cmd.data    <= '0;   // unused on reads
      end
   end

endmodule

/* logic/capture_buffer.sv */
`timescale 1ns/1ps

module capture_buffer
   import acquire_pkg::*;
(
   input  logic                clock,
   input  logic                reset,
   input  logic                sample_strobe,
   input  logic [SAMPLE_W-1:0] sample_data,
   input  logic [BUF_AW-1:0]   read_address,
   output logic [BUF_AW-1:0]   write_address,
   output logic [SAMPLE_W-1:0] read_data
);

   logic [1:0]          strobe_sync;   // two-flop synchronizer
   logic                write_strobe;
   logic [SAMPLE_W-1:0] data_d1;
   logic [SAMPLE_W-1:0] data_d2;
   logic [SAMPLE_W-1:0] buffer_mem [BUF_DEPTH];

   assign write_strobe = strobe_sync[1];

   // strobe synchronizer and write pointer
   always_ff @(posedge clock or posedge reset)
   begin
      if (reset)
      begin
         strobe_sync   <= '0;
         write_address <= '0;
      end
      else
      begin
         strobe_sync <= {strobe_sync[0], sample_strobe};
         if (write_strobe)
            write_address <= write_address + 1'b1;   // wraps at 512
      end
   end

   // data is held for 3 cycles by the source, so a two-stage delay
   // lines it up with the synchronized strobe and sees settled bits
   always_ff @(posedge clock)
   begin
      data_d1 <= sample_data;
      data_d2 <= data_d1;
   end

   // block RAM with a registered read port
   always_ff @(posedge clock)
   begin
      if (write_strobe)
         buffer_mem[write_address] <= data_d2;
      read_data <= buffer_mem[read_address];   // word at read_address, one cycle later
   end

endmodule

/* logic/acquire_pkg.sv */
package acquire_pkg;

   // sample and buffer sizes
   localparam int SAMPLE_W  = 24;
   localparam int BUF_AW    = 9;
   localparam int BUF_DEPTH = 1 << BUF_AW;   // 512 entries

   // bulk store geometry, kept small for simulation
   localparam int STORE_AW    = 6;
   localparam int STORE_DEPTH = 1 << STORE_AW;   // 64 words
   localparam int CMD_DATA_W  = 32;

   // store timing
   localparam int STORE_BUSY   = 3;   // cycles of cmd_ready low per command
   localparam int READ_LATENCY = 2;   // accepted read to readback.valid
   localparam int BUSY_W       = $clog2(STORE_BUSY + 1);

   // command word on the store port
   typedef struct packed
   {
      logic                  write;   // 1 = write, 0 = read
      logic [STORE_AW-1:0]   address;
      logic [CMD_DATA_W-1:0] data;
   } store_cmd_t;

   // read return from the store
   typedef struct packed
   {
      logic                  valid;
      logic [CMD_DATA_W-1:0] data;
   } readback_t;

   // scheduler phases, encoded as in the original front end
   typedef enum logic [2:0]
   {
      phase_waiting         = 3'd0,
      phase_buffer_to_store = 3'd1,
      phase_store_reading   = 3'd2,
      phase_read_idle       = 3'd3,
      phase_finished        = 3'd4
   } acq_phase_t;

endpackage
